//--- Makefile
# Verilator build and run for the timing sequencer

VERILATOR ?= verilator
TOP       ?= tb_timing_synch
FILELIST  ?= timing_synch.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) logic/*.sv logic/*.svh testbench/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run passed"; \
	else \
		echo "run failed (exit $$status)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/adc_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "timing_synch_defs.svh"

module adc_sequencer
	import timing_synch_pkg::*;
(
	input  wire logic        fastClk,
	input  wire logic        rst,
	input  wire logic        trig,
	input  wire logic        sync_tick,
	input  wire logic        sampling_done,
	input  wire timing_cfg_t cfg,
	output seq_state_e       state,
	output logic             sample_start,
	output logic             adc_powerup,
	output logic             adc_align_en
);

	// last count value of each fixed phase
	localparam logic [`WARMUP_W-1:0] WARM_LAST  = `WARMUP_W'(`WARMUP_CYCLES);
	localparam logic [`ALIGN_W-1:0]  ALIGN_LAST = `ALIGN_W'(`ALIGN_CYCLES);

	// trigger latch
	logic triggered;

	// ring ticks since the trigger
	logic [`TRIG_DELAY_W-1:0] tick_cnt;

	// phase counters
	logic [`WARMUP_W-1:0] warm_cnt;
	logic [`ALIGN_W-1:0]  align_cnt;

	//////////////////////////////
	// main FSM
	//////////////////////////////

	always_ff @(posedge fastClk) begin
		if (rst) begin
			state        <= ST_IDLE;
			triggered    <= 1'b0;
			tick_cnt     <= '0;
			warm_cnt     <= '0;
			align_cnt    <= '0;
			sample_start <= 1'b0;
			adc_powerup  <= 1'b0;
			adc_align_en <= 1'b0;
		end else begin
			// single cycle strobe
			sample_start <= 1'b0;

			case (state)
				ST_IDLE: begin
					warm_cnt <= '0;
					if (!triggered) begin
						// arm, later trig pulses ignored
						if (trig) begin
							triggered <= 1'b1;
							tick_cnt  <= '0;
						end
					end else if (tick_cnt == cfg.trig_delay) begin
						// delay reached, power up the adcs
						state       <= ST_WARM_UP;
						adc_powerup <= 1'b1;
					end else if (sync_tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end

				ST_WARM_UP: begin
					// WARMUP_CYCLES + 1 cycles in here
					if (warm_cnt == WARM_LAST) begin
						state        <= ST_SAMPLING;
						sample_start <= 1'b1;
					end else begin
						warm_cnt <= warm_cnt + 1'b1;
					end
				end

				ST_SAMPLING: begin
					align_cnt <= '0;
					// store window reports the end
					if (sampling_done) begin
						state        <= ST_ALIGN;
						adc_align_en <= 1'b1;
					end
				end

				ST_ALIGN: begin
					// ALIGN_CYCLES + 1 cycles, then power down
					if (align_cnt == ALIGN_LAST) begin
						state        <= ST_IDLE;
						triggered    <= 1'b0;
						adc_align_en <= 1'b0;
						adc_powerup  <= 1'b0;
					end else begin
						align_cnt <= align_cnt + 1'b1;
					end
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	// align enable is a level of the align phase only
	a_align_in_state : assert property (@(posedge fastClk) disable iff (rst)
		adc_align_en |-> state == ST_ALIGN)
		else $error("adc_sequencer: adc_align_en outside ST_ALIGN");

	// store window must only finish while sampling
	a_done_in_sampling : assert property (@(posedge fastClk) disable iff (rst)
		sampling_done |-> state == ST_SAMPLING)
		else $error("adc_sequencer: sampling_done outside ST_SAMPLING");

endmodule

`default_nettype wire

//--- logic/ring_tick_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "timing_synch_defs.svh"

module ring_tick_gen
	import timing_synch_pkg::*;
(
	input  wire logic        fastClk,
	input  wire logic        rst,
	input  wire logic        ring_clk_ext,
	input  wire timing_cfg_t cfg,
	output logic             sync_tick
);

	//////////////////////////////
	// ring clock synchronizer
	//////////////////////////////

	// three flops, async pin
	logic ext_a;
	logic ext_b;
	logic ext_c;

	always_ff @(posedge fastClk) begin
		ext_a <= ring_clk_ext;
		ext_b <= ext_a;
		ext_c <= ext_b;
	end

	// edge from the last two stages
	logic ext_rise;
	logic ext_fall;
	logic ext_edge;

	assign ext_rise = ext_b & ~ext_c;
	assign ext_fall = ~ext_b & ext_c;
	assign ext_edge = cfg.ext_edge_sel ? ext_rise : ext_fall;

	//////////////////////////////
	// tick counter
	//////////////////////////////

	logic                    counting;
	logic [`SYNC_SIZE_W-1:0] tick_ctr;

	// latch start of counting, held until reset
	always_ff @(posedge fastClk) begin
		if (rst) begin
			counting <= 1'b0;
		end else if (!counting) begin
			// free run starts right away
			counting <= cfg.use_ext_sync ? ext_edge : 1'b1;
		end
	end

	// period is sync_size + 1
	always_ff @(posedge fastClk) begin
		if (rst) begin
			tick_ctr  <= '0;
			sync_tick <= 1'b0;
		end else if (!counting) begin
			tick_ctr  <= '0;
			sync_tick <= 1'b0;
		end else if (tick_ctr == cfg.sync_size) begin
			// wrap, one tick per wrap
			tick_ctr  <= '0;
			sync_tick <= 1'b1;
		end else begin
			tick_ctr  <= tick_ctr + 1'b1;
			sync_tick <= 1'b0;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	// ticks are single cycle unless period is one cycle
	a_tick_single : assert property (@(posedge fastClk) disable iff (rst)
		(sync_tick && cfg.sync_size != '0) |=> !sync_tick)
		else $error("ring_tick_gen: sync_tick high on consecutive cycles");

endmodule

`default_nettype wire

//--- logic/store_window.sv
`timescale 1ns/10ps
`default_nettype none

`include "timing_synch_defs.svh"

module store_window
	import timing_synch_pkg::*;
(
	input  wire logic        fastClk,
	input  wire logic        rst,
	input  wire logic        sample_start,
	input  wire timing_cfg_t cfg,
	output logic             store_strb,
	output logic             sampling_done
);

	localparam int CNT_W = `SAMPLE_CNT_W;

	//////////////////////////////
	// window limits
	//////////////////////////////

	logic [`HOLD_OFF_W-1:0] start_val;
	logic [CNT_W-1:0]       end_val;

	// registered for timing, cfg is static while idle
	always_ff @(posedge fastClk) begin
		start_val <= cfg.sample_hold_off;
		end_val   <= CNT_W'(cfg.sample_hold_off) + CNT_W'(cfg.num_smpls);
	end

	//////////////////////////////
	// sample counter
	//////////////////////////////

	logic             counting;
	logic [CNT_W-1:0] smpl_cnt;

	always_ff @(posedge fastClk) begin
		if (rst) begin
			counting      <= 1'b0;
			smpl_cnt      <= '0;
			store_strb    <= 1'b0;
			sampling_done <= 1'b0;
		end else begin
			sampling_done <= 1'b0;
			if (!counting) begin
				// count from 0 on the cycle after the start strobe
				smpl_cnt <= '0;
				counting <= sample_start;
			end else begin
				smpl_cnt <= smpl_cnt + 1'b1;
				// end wins, so zero samples never raises the strobe
				if (smpl_cnt == end_val) begin
					counting      <= 1'b0;
					store_strb    <= 1'b0;
					sampling_done <= 1'b1;
				end else if (smpl_cnt == CNT_W'(start_val)) begin
					store_strb <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	// one window at a time
	a_no_restart : assert property (@(posedge fastClk) disable iff (rst)
		sample_start |-> !counting)
		else $error("store_window: sample_start while counting");

endmodule

`default_nettype wire

//--- logic/timing_synch.sv
`timescale 1ns/10ps
`default_nettype none

module timing_synch
	import timing_synch_pkg::*;
(
	input  wire logic        fastClk,
	input  wire logic        rst,
	input  wire logic        ring_clk_ext,
	input  wire logic        trig,
	input  wire timing_cfg_t cfg,
	output adc_ctrl_t        adc_ctrl,
	output seq_state_e       state,
	output logic             sync_tick
);

	// strobes between the blocks
	logic sample_start;
	logic sampling_done;

	// control levels
	logic store_strb;
	logic adc_powerup;
	logic adc_align_en;

	//////////////////////////////
	// tick -> sequencer -> window
	//////////////////////////////

	ring_tick_gen u_ring_tick_gen (
		.fastClk      (fastClk),
		.rst          (rst),
		.ring_clk_ext (ring_clk_ext),
		.cfg          (cfg),
		.sync_tick    (sync_tick)
	);

	adc_sequencer u_adc_sequencer (
		.fastClk       (fastClk),
		.rst           (rst),
		.trig          (trig),
		.sync_tick     (sync_tick),
		.sampling_done (sampling_done),
		.cfg           (cfg),
		.state         (state),
		.sample_start  (sample_start),
		.adc_powerup   (adc_powerup),
		.adc_align_en  (adc_align_en)
	);

	// window reports done back to the sequencer
	store_window u_store_window (
		.fastClk       (fastClk),
		.rst           (rst),
		.sample_start  (sample_start),
		.cfg           (cfg),
		.store_strb    (store_strb),
		.sampling_done (sampling_done)
	);

	// pack outputs
	assign adc_ctrl = '{
		adc_powerup:  adc_powerup,
		adc_align_en: adc_align_en,
		store_strb:   store_strb
	};

endmodule

`default_nettype wire

//--- logic/timing_synch_defs.svh
`ifndef TIMING_SYNCH_DEFS_SVH
`define TIMING_SYNCH_DEFS_SVH

//////////////////////////////
// configuration field widths
//////////////////////////////
`define TRIG_DELAY_W   12
`define HOLD_OFF_W     7
`define NUM_SMPLS_W    10
`define SYNC_SIZE_W    8

// store window counter, holds hold-off plus sample count
`define SAMPLE_CNT_W   11

//////////////////////////////
// fixed phase lengths, fastClk cycles
//////////////////////////////
`define WARMUP_CYCLES  3300
`define WARMUP_W       12
// alignment now counted here, no slow clock
`define ALIGN_CYCLES   10000
`define ALIGN_W        14

`endif

//--- logic/timing_synch_pkg.sv
`default_nettype none

package timing_synch_pkg;

`include "timing_synch_defs.svh"

	// sequencer states
	typedef enum logic [1:0] {
		ST_IDLE     = 2'd0,
		ST_WARM_UP  = 2'd1,
		ST_SAMPLING = 2'd2,
		ST_ALIGN    = 2'd3
	} seq_state_e;

	// quasi-static config, only touched while idle
	typedef struct packed {
		logic [`TRIG_DELAY_W-1:0] trig_delay;
		logic [`HOLD_OFF_W-1:0]   sample_hold_off;
		logic [`NUM_SMPLS_W-1:0]  num_smpls;
		// tick period minus one
		logic [`SYNC_SIZE_W-1:0]  sync_size;
		logic                     use_ext_sync;
		// 1 = rising edges of ring clock
		logic                     ext_edge_sel;
	} timing_cfg_t;

	// adc control levels out of the top
	typedef struct packed {
		logic adc_powerup;
		logic adc_align_en;
		logic store_strb;
	} adc_ctrl_t;

endpackage

`default_nettype wire

//--- testbench/tb_timing_synch.sv
`timescale 1ns/10ps
`default_nettype none

`include "timing_synch_defs.svh"

module tb_timing_synch
	import timing_synch_pkg::*;
();

	localparam int RUNS       = 4;
	localparam int RUN_CYCLES = `WARMUP_CYCLES + `ALIGN_CYCLES + 1000;
	// all trigger runs plus the tick tests
	localparam int LIMIT      = RUNS * RUN_CYCLES + 2000;

	logic        fastClk;
	logic        rst;
	logic        ring_clk_ext;
	logic        trig;
	timing_cfg_t cfg;
	adc_ctrl_t   adc_ctrl;
	seq_state_e  state;
	logic        sync_tick;

	timing_synch u_timing_synch (
		.fastClk      (fastClk),
		.rst          (rst),
		.ring_clk_ext (ring_clk_ext),
		.trig         (trig),
		.cfg          (cfg),
		.adc_ctrl     (adc_ctrl),
		.state        (state),
		.sync_tick    (sync_tick)
	);

	initial begin
		fastClk = 1'b0;
		forever #5 fastClk = ~fastClk;
	end

	//////////////////////////////
	// bookkeeping
	//////////////////////////////

	int         err_cnt = 0;
	int         cycle_cnt = 0;
	logic [7:0] lfsr = 8'd38;
	logic       sel_edge_driven;

	// reference counters, updated from sampled values
	logic       armed;
	int         ref_cnt;
	int         tick_gap;
	logic       tick_seen;
	int         samp_age;
	int         strb_len;
	int         align_len;
	seq_state_e prev_state;

	task automatic report_mismatch(input string name, input int expected, input int actual);
		err_cnt++;
		$display("FAILED t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
	endtask

	task automatic report_problem(input string what);
		err_cnt++;
		$display("ERROR t=%0t %s", $time, what);
	endtask

	// galois lfsr, one step per bit taken
	function automatic int draw_bits(input int n);
		int val;
		val = 0;
		for (int i = 0; i < n; i++) begin
			val  = (val << 1) | int'(lfsr[0]);
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 8'hB8) : (lfsr >> 1);
		end
		return val;
	endfunction

	always @(posedge fastClk) begin
		if (rst) begin
			armed     <= 1'b0;
			ref_cnt   <= 0;
			tick_gap  <= 0;
			tick_seen <= 1'b0;
			samp_age  <= 0;
			strb_len  <= 0;
			align_len <= 0;
		end else begin
			// trigger latch and tick count as the sequence defines them
			// latch is gone by the time the sequence is back in idle
			if (state == ST_ALIGN) begin
				armed <= 1'b0;
			end else if (!armed && state == ST_IDLE && trig) begin
				armed   <= 1'b1;
				ref_cnt <= 0;
			end else if (armed && state == ST_IDLE && sync_tick
					&& ref_cnt != int'(cfg.trig_delay)) begin
				ref_cnt <= ref_cnt + 1;
			end
			tick_gap  <= sync_tick ? 1 : tick_gap + 1;
			tick_seen <= tick_seen | sync_tick;
			samp_age  <= (state == ST_SAMPLING && prev_state != ST_SAMPLING) ? 1 : samp_age + 1;
			strb_len  <= adc_ctrl.store_strb ? strb_len + 1 : 0;
			align_len <= adc_ctrl.adc_align_en ? align_len + 1 : 0;
		end
		prev_state <= state;
	end

	// hard stop
	always @(posedge fastClk) begin
		cycle_cnt++;
		if (cycle_cnt >= LIMIT) begin
			$display("timeout after %0d cycles, sequence never finished", cycle_cnt);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	a_reset_ctrl : assert property (@(posedge fastClk)
		$fell(rst) |-> adc_ctrl == '0)
		else report_mismatch("adc_ctrl", 0, int'($sampled(adc_ctrl)));

	a_reset_state : assert property (@(posedge fastClk)
		$fell(rst) |-> state == ST_IDLE)
		else report_mismatch("state", int'(ST_IDLE), int'($sampled(state)));

	a_tick_period : assert property (@(posedge fastClk) disable iff (rst)
		(sync_tick && tick_seen) |-> tick_gap == int'(cfg.sync_size) + 1)
		else report_mismatch("sync_tick period", int'(cfg.sync_size) + 1, $sampled(tick_gap));

	a_ext_start : assert property (@(posedge fastClk) disable iff (rst)
		sync_tick |-> (!cfg.use_ext_sync || sel_edge_driven))
		else report_problem("sync_tick before the selected ring clock edge");

	a_no_early_pu : assert property (@(posedge fastClk) disable iff (rst)
		(armed && state == ST_IDLE && ref_cnt != int'(cfg.trig_delay)) |-> !adc_ctrl.adc_powerup)
		else report_mismatch("adc_powerup", 0, 1);

	a_pu_on_time : assert property (@(posedge fastClk) disable iff (rst)
		(armed && state == ST_IDLE && ref_cnt == int'(cfg.trig_delay) && !adc_ctrl.adc_powerup)
		|=> adc_ctrl.adc_powerup)
		else report_mismatch("adc_powerup", 1, 0);

	// count must already be complete on the cycle before the rise
	a_pu_rise : assert property (@(posedge fastClk) disable iff (rst)
		$rose(adc_ctrl.adc_powerup) |-> $past(ref_cnt) == int'(cfg.trig_delay))
		else report_mismatch("ticks before adc_powerup", int'(cfg.trig_delay),
			$past(ref_cnt));

	a_strb_rise : assert property (@(posedge fastClk) disable iff (rst)
		$rose(adc_ctrl.store_strb) |-> samp_age == int'(cfg.sample_hold_off) + 2)
		else report_mismatch("store_strb delay", int'(cfg.sample_hold_off) + 2,
			$sampled(samp_age));

	a_strb_len : assert property (@(posedge fastClk) disable iff (rst)
		$fell(adc_ctrl.store_strb) |-> strb_len == int'(cfg.num_smpls))
		else report_mismatch("store_strb length", int'(cfg.num_smpls), $sampled(strb_len));

	a_align_follows : assert property (@(posedge fastClk) disable iff (rst)
		$fell(adc_ctrl.store_strb) |=> $rose(adc_ctrl.adc_align_en))
		else report_mismatch("adc_align_en", 1, int'($sampled(adc_ctrl.adc_align_en)));

	a_align_len : assert property (@(posedge fastClk) disable iff (rst)
		$fell(adc_ctrl.adc_align_en) |-> align_len == `ALIGN_CYCLES + 1)
		else report_mismatch("adc_align_en length", `ALIGN_CYCLES + 1, $sampled(align_len));

	a_power_down : assert property (@(posedge fastClk) disable iff (rst)
		$fell(adc_ctrl.adc_align_en) |-> ($fell(adc_ctrl.adc_powerup) && state == ST_IDLE))
		else report_mismatch("adc_powerup", 0, int'($sampled(adc_ctrl.adc_powerup)));

	// sampling start to idle, fixed length
	a_seq_latency : assert property (@(posedge fastClk) disable iff (rst)
		$fell(adc_ctrl.adc_align_en)
		|-> samp_age == int'(cfg.sample_hold_off) + int'(cfg.num_smpls) + `ALIGN_CYCLES + 4)
		else report_mismatch("sampling to idle",
			int'(cfg.sample_hold_off) + int'(cfg.num_smpls) + `ALIGN_CYCLES + 4,
			$sampled(samp_age));

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	task automatic apply_reset();
		rst = 1'b1;
		repeat (3) @(negedge fastClk);
		rst = 1'b0;
	endtask

	task automatic wait_state(input seq_state_e s, input int limit, input string what);
		int n;
		n = 0;
		while (state != s && n < limit) begin
			@(negedge fastClk);
			n++;
		end
		if (state != s)
			report_problem({"state never reached ", what});
	endtask

	task automatic wait_ticks(input int count, input int limit);
		int n;
		int seen;
		n = 0;
		seen = 0;
		while (seen < count && n < limit) begin
			@(negedge fastClk);
			if (sync_tick)
				seen++;
			n++;
		end
		if (seen < count)
			report_problem("too few sync_tick pulses");
	endtask

	task automatic pulse_trig();
		trig = 1'b1;
		@(negedge fastClk);
		trig = 1'b0;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (err_cnt == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, err_cnt - errs_before);
	endtask

	task automatic run_trigger(input int idx);
		int errs;
		int d;
		errs = err_cnt;
		d = draw_bits(4);
		cfg.trig_delay      = `TRIG_DELAY_W'(d + 1);
		cfg.sample_hold_off = `HOLD_OFF_W'(3 + 2 * idx);
		cfg.num_smpls       = `NUM_SMPLS_W'(16 + idx);
		@(negedge fastClk);
		pulse_trig();
		wait_state(ST_WARM_UP, 400, "warm up");
		// stray trigger while busy
		repeat (10) @(negedge fastClk);
		pulse_trig();
		wait_state(ST_SAMPLING, `WARMUP_CYCLES + 20, "sampling");
		wait_state(ST_ALIGN, 400, "align");
		wait_state(ST_IDLE, `ALIGN_CYCLES + 20, "idle");
		repeat (5) @(negedge fastClk);
		finish_test($sformatf("trigger run %0d (delay %0d)", idx, d + 1), errs);
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		int errs;
		int sel;
		rst             = 1'b1;
		trig            = 1'b0;
		ring_clk_ext    = 1'b0;
		sel_edge_driven = 1'b0;
		cfg             = '0;
		cfg.sync_size   = 8'd9;

		errs = err_cnt;
		apply_reset();
		@(negedge fastClk);
		finish_test("reset values", errs);

		errs = err_cnt;
		wait_ticks(10, 200);
		finish_test("internal tick period", errs);

		for (int i = 0; i < RUNS; i++)
			run_trigger(i);

		// external start, idle level opposite to the chosen edge
		errs = err_cnt;
		sel = draw_bits(1);
		cfg.use_ext_sync = 1'b1;
		cfg.ext_edge_sel = sel[0];
		cfg.sync_size    = 8'd6;
		ring_clk_ext     = sel[0];
		apply_reset();
		repeat (5) @(negedge fastClk);
		ring_clk_ext = ~sel[0];
		repeat (30) @(negedge fastClk);
		ring_clk_ext    = sel[0];
		sel_edge_driven = 1'b1;
		wait_ticks(6, 100);
		finish_test("external tick start", errs);

		$display("tests run %0d, errors %0d", RUNS + 3, err_cnt);
		if (err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- timing_synch.f
+incdir+logic
logic/timing_synch_pkg.sv
logic/ring_tick_gen.sv
logic/adc_sequencer.sv
logic/store_window.sv
logic/timing_synch.sv
testbench/tb_timing_synch.sv
